/* files.f */
+incdir+include
src/exec_pkg.sv
src/pipe_stage.sv
src/reg_file.sv
src/issue_scoreboard.sv
src/exec_alu.sv
src/exec_cluster.sv
tb/tb_exec_cluster.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
  -f files.f --top-module tb_exec_cluster -o sim_exec_cluster

./obj_dir/sim_exec_cluster > sim.log 2>&1 || true
cat sim.log

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log
echo "run.sh: simulation passed"

/* tb/tb_exec_cluster.sv */
module tb_exec_cluster;
  timeunit 1ns;
  timeprecision 1ps;
  import exec_pkg::*;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic in_valid = 1'b0;
  logic in_ready;
  dispatch_t disp = '0;
  logic out_valid;
  logic out_ready = 1'b1;
  result_t out;

  logic [31:0] rnd_state = 32'd23;
  logic [31:0] rdy_state = 32'd23 ^ 32'h9e3779b9;  // separate stream for out_ready
  logic        bp_mode = 1'b0;
  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  int          cycles = 0;
  int          n_sent = 0;
  int          n_acc = 0;
  int          n_res = 0;

  logic [31:0] m_regs [16];
  flags_t      m_flags;
  int          pend [16];
  int          fl_pend;
  result_t     exp_q [$];
  logic        fl_q [$];
  result_t     exp_head = '0;
  logic        exp_fl = 1'b0;   // flags field is meaningful for the head
  logic        exp_empty = 1'b1;
  logic        hold_prev = 1'b0;
  result_t     out_prev = '0;

  exec_cluster u_exec_cluster (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready), .in(disp),
    .out_valid(out_valid), .out_ready(out_ready), .out(out)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] rnd();
    rnd_state = xorshift(rnd_state);
    return rnd_state;
  endfunction

  // odd codes are the inverse of the even code before them
  function automatic logic cond_holds(input logic [3:0] cc, input flags_t f);
    logic base;
    case (cc[3:1])
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.s;
      3'd3: base = f.v;
      3'd4: base = f.c && !f.z;
      3'd5: base = (f.s == f.v);
      3'd6: base = (f.s == f.v) && !f.z;
      default: return cc == 4'd14;
    endcase
    return cc[0] ? !base : base;
  endfunction

  function automatic result_t predict(input dispatch_t d);
    result_t r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    longint wide;
    flags_t nf;
    a = m_regs[d.src_a];
    b = d.use_imm ? d.imm : m_regs[d.src_b];
    nf = '0;
    case (d.op)
      op_add: begin
        v = a + b;
        wide = longint'($signed(a)) + longint'($signed(b));
        nf.c = v < a;
        nf.v = wide != longint'($signed(v));  // true sum does not fit
      end
      op_sub: begin
        v = a - b;
        wide = longint'($signed(a)) - longint'($signed(b));
        nf.c = a >= b;
        nf.v = wide != longint'($signed(v));
      end
      op_and: v = a & b;
      op_or: v = a | b;
      op_xor: v = a ^ b;
      op_shl: v = a << b[4:0];
      op_shr: v = a >> b[4:0];
      op_sar: v = 32'($signed(a) >>> b[4:0]);
      op_sxtb: v = 32'($signed(a[7:0]));
      op_sxth: v = 32'($signed(a[15:0]));
      op_bswap: v = {a[7:0], a[15:8], a[23:16], a[31:24]};
      default: v = b;
    endcase
    nf.s = v[31];
    nf.z = (v == 0);
    r.dst = d.dst;
    r.value = v;
    r.executed = cond_holds(d.cond, m_flags);
    r.set_flags = d.set_flags;
    r.flags = (r.executed && d.set_flags) ? nf : m_flags;
    return r;
  endfunction

  function automatic dispatch_t mk(input alu_op_e op, input cond_e cc, input int dst,
                                   input int sa, input int sb, input logic ui,
                                   input logic [31:0] imm, input logic sf);
    dispatch_t d;
    d.op = op;
    d.cond = cc;
    d.dst = 4'(dst);
    d.src_a = 4'(sa);
    d.src_b = 4'(sb);
    d.use_imm = ui;
    d.imm = imm;
    d.set_flags = sf;
    return d;
  endfunction

  function automatic dispatch_t rand_op(input int nreg);
    logic [31:0] r;
    logic [31:0] k;
    r = rnd();
    k = rnd();
    return mk(alu_op_e'(r % 12), r[8] ? cond_al : cond_e'(r[15:12]), int'(r[19:16]) % nreg,
              int'(r[23:20]) % nreg, int'(r[27:24]) % nreg, r[28],
              k[0] ? k : {27'd0, k[5:1]}, r[29]);
  endfunction

  task automatic send(input dispatch_t d);
    n_sent++;
    @(negedge clk);
    in_valid = 1'b1;
    disp = d;
    do @(posedge clk); while (!in_ready);
  endtask

  task automatic finish_ops();
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  always @(negedge clk) begin
    if (bp_mode) begin
      rdy_state = xorshift(rdy_state);
      out_ready = rdy_state[7];
    end
  end

  // reference model advances only on handshakes
  always @(posedge clk) begin
    result_t e;
    result_t h;
    logic nfl;
    if (rst) begin
      foreach (m_regs[i]) m_regs[i] = '0;
      foreach (pend[i]) pend[i] = 0;
      m_flags = '0;
      fl_pend = 0;
      exp_q.delete();
      fl_q.delete();
    end else begin
      if (in_valid && in_ready) begin
        nfl = (disp.cond != cond_al) || disp.set_flags;
        a_no_hazard: assert (pend[disp.src_a] == 0 && (disp.use_imm || pend[disp.src_b] == 0)
                             && !(nfl && fl_pend != 0))
        else begin
          fail_cnt++;
          $display("op accepted while one of its sources was still in flight");
        end
        e = predict(disp);
        exp_q.push_back(e);
        fl_q.push_back(nfl);
        pend[disp.dst]++;
        if (disp.set_flags) fl_pend++;
        n_acc++;
      end
      if (out_valid && out_ready) begin
        n_res++;
        if (exp_q.size() != 0) begin
          h = exp_q.pop_front();
          void'(fl_q.pop_front());
          if (h.executed) m_regs[h.dst] = h.value;
          if (h.executed && h.set_flags) m_flags = h.flags;
          pend[h.dst]--;
          if (h.set_flags) fl_pend--;
        end
      end
    end
    exp_empty = (exp_q.size() == 0);
    exp_head = exp_empty ? '0 : exp_q[0];
    exp_fl = exp_empty ? 1'b0 : fl_q[0];
  end

  always @(posedge clk) begin
    hold_prev <= out_valid && !out_ready && !rst;
    out_prev <= out;
  end

  a_expected: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> !exp_empty)
  else begin
    fail_cnt++;
    $display("result appeared with no dispatched op outstanding");
  end

  a_value: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && !exp_empty |-> out.value == exp_head.value)
  else begin
    mismatch_cnt++;
    $display("mismatch out.value got %h exp %h", $sampled(out.value), $sampled(exp_head.value));
  end

  a_ctrl: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && !exp_empty |->
      {out.dst, out.executed, out.set_flags} ==
      {exp_head.dst, exp_head.executed, exp_head.set_flags})
  else begin
    mismatch_cnt++;
    $display("mismatch out.dst/executed/set_flags got %h exp %h",
             $sampled({out.dst, out.executed, out.set_flags}),
             $sampled({exp_head.dst, exp_head.executed, exp_head.set_flags}));
  end

  a_flags: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && exp_fl |-> out.flags == exp_head.flags)
  else begin
    mismatch_cnt++;
    $display("mismatch out.flags got %h exp %h", $sampled(out.flags), $sampled(exp_head.flags));
  end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    hold_prev |-> out_valid && out == out_prev)
  else begin
    fail_cnt++;
    $display("stalled result was dropped or changed");
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 4 * n_sent + 200) begin
      $display("timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [31:0] vals [5];
    vals = '{32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h1, 32'h0};
    repeat (2) @(posedge clk);
    @(negedge clk) rst = 1'b0;
    @(posedge clk);
    a_reset: assert (!out_valid) else begin
      fail_cnt++;
      $display("out_valid high right after reset");
    end
    for (int r = 0; r < 16; r++) send(mk(op_add, cond_al, r, r, 0, 1'b1, 0, 1'b0));

    for (int i = 0; i < 5; i++) send(mk(op_movi, cond_al, i + 1, 0, 0, 1'b1, vals[i], 1'b0));
    for (int i = 1; i <= 5; i++) begin
      for (int j = 1; j <= 5; j++) begin
        send(mk(op_add, cond_al, 6, i, j, 1'b0, 0, 1'b1));
        send(mk(op_sub, cond_al, 7, i, j, 1'b0, 0, 1'b1));
      end
    end

    for (int k = 2; k < 12; k++) begin
      send(mk(op_add, cond_al, 8, 2, 2, 1'b0, 0, 1'b1));  // 0x80000000 twice sets c and v
      send(mk(alu_op_e'(k), cond_al, 9, 1 + k % 3, 0, 1'b1, rnd(), 1'b1));
    end

    for (int cc = 0; cc < 16; cc++) begin
      for (int p = 0; p < 3; p++) begin
        // p == 2 subtracts r3 from itself for z
        send(mk(op_sub, cond_al, 8, 1 + p, (p == 2) ? 3 : 3 + p, 1'b0, 0, 1'b1));
        send(mk(op_movi, cond_e'(cc), 9, 0, 0, 1'b1, rnd(), 1'b1));
        send(mk(op_add, cond_al, 10, 9, 0, 1'b1, 0, 1'b0));
        send(mk(op_or, cond_nv, 11, 9, 0, 1'b1, 0, 1'b0));
      end
    end
    finish_ops();

    for (int n = 0; n < 300; n++) send(rand_op(4));
    finish_ops();

    bp_mode = 1'b1;
    for (int n = 0; n < 200; n++) send(rand_op(16));
    finish_ops();
    bp_mode = 1'b0;
    out_ready = 1'b1;
    repeat (4) @(posedge clk);
    a_count: assert (n_res == n_acc && n_acc == n_sent) else begin
      fail_cnt++;
      $display("sent %0d ops, accepted %0d, got %0d results", n_sent, n_acc, n_res);
    end

    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* src/exec_cluster.sv */
module exec_cluster (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  exec_pkg::dispatch_t in,
  output logic                out_valid,
  input  logic                out_ready,
  output exec_pkg::result_t   out
);

  import exec_pkg::*;

  reg_idx_t rd_a_idx;
  reg_idx_t rd_b_idx;
  word_t    rd_a;
  word_t    rd_b;
  flags_t   flags;

  logic     iss_valid;
  logic     iss_ready;
  exec_t    iss;

  logic     ex_valid;
  logic     ex_ready;
  exec_t    ex;
  result_t  ex_res;

  logic     wb_valid;

  // writeback happens on the result handshake
  assign wb_valid = out_valid & out_ready;

  issue_scoreboard u_issue (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in        (in),
    .rd_a_idx  (rd_a_idx),
    .rd_b_idx  (rd_b_idx),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .flags     (flags),
    .iss_valid (iss_valid),
    .iss_ready (iss_ready),
    .iss       (iss),
    .wb_valid  (wb_valid),
    .wb        (out)
  );

  pipe_stage #(.payload_t(exec_t)) u_ex_stage (
    .clk      (clk),
    .rst      (rst),
    .up_valid (iss_valid),
    .up_ready (iss_ready),
    .up_data  (iss),
    .dn_valid (ex_valid),
    .dn_ready (ex_ready),
    .dn_data  (ex)
  );

  exec_alu u_alu (
    .ex  (ex),
    .res (ex_res)
  );

  pipe_stage #(.payload_t(result_t)) u_wb_stage (
    .clk      (clk),
    .rst      (rst),
    .up_valid (ex_valid),
    .up_ready (ex_ready),
    .up_data  (ex_res),
    .dn_valid (out_valid),
    .dn_ready (out_ready),
    .dn_data  (out)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rd_a_idx (rd_a_idx),
    .rd_b_idx (rd_b_idx),
    .rd_a     (rd_a),
    .rd_b     (rd_b),
    .flags    (flags),
    .wr_en    (wb_valid & out.executed),
    .wr_idx   (out.dst),
    .wr_data  (out.value),
    .fl_wr_en (wb_valid & out.executed & out.set_flags),
    .fl_wr    (out.flags)
  );

endmodule

/* src/exec_alu.sv */
module exec_alu (
  input  exec_pkg::exec_t   ex,
  output exec_pkg::result_t res
);

  import exec_pkg::*;

  localparam int XW  = $bits(word_t);
  localparam int SHW = $clog2(XW);

  word_t        a;
  word_t        b;
  word_t        value;
  logic [XW:0]  sum_add;
  logic [XW:0]  sum_sub;
  logic         cond_ok;
  flags_t       calc;

  function automatic logic cond_true(cond_e cc, flags_t f);
    logic ge;
    ge = (f.s == f.v);
    case (cc)
      cond_eq: return f.z;
      cond_ne: return ~f.z;
      cond_cs: return f.c;
      cond_cc: return ~f.c;
      cond_mi: return f.s;
      cond_pl: return ~f.s;
      cond_vs: return f.v;
      cond_vc: return ~f.v;
      cond_hi: return f.c & ~f.z;
      cond_ls: return ~f.c | f.z;
      cond_ge: return ge;
      cond_lt: return ~ge;
      cond_gt: return ge & ~f.z;
      cond_le: return ~ge | f.z;
      cond_al: return 1'b1;
      default: return 1'b0;  // nv
    endcase
  endfunction

  assign a = ex.a;
  assign b = ex.b;

  assign sum_add = {1'b0, a} + {1'b0, b};
  assign sum_sub = {1'b0, a} + {1'b0, ~b} + 1'b1;  // carry set means no borrow

  assign cond_ok = cond_true(ex.cond, ex.flags);

  always_comb begin
    value  = '0;
    calc.c = 1'b0;
    calc.v = 1'b0;
    case (ex.op)
      op_add: begin
        value  = sum_add[XW-1:0];
        calc.c = sum_add[XW];
        calc.v = (a[XW-1] == b[XW-1]) && (sum_add[XW-1] != a[XW-1]);
      end
      op_sub: begin
        value  = sum_sub[XW-1:0];
        calc.c = sum_sub[XW];
        calc.v = (a[XW-1] != b[XW-1]) && (sum_sub[XW-1] != a[XW-1]);
      end
      op_and:  value = a & b;
      op_or:   value = a | b;
      op_xor:  value = a ^ b;
      op_shl:  value = a << b[SHW-1:0];
      op_shr:  value = a >> b[SHW-1:0];
      op_sar:  value = word_t'($signed(a) >>> b[SHW-1:0]);
      op_sxtb: value = {{(XW - 8){a[7]}}, a[7:0]};
      op_sxth: value = {{(XW - 16){a[15]}}, a[15:0]};
      op_bswap: begin
        for (int i = 0; i < XW / 8; i++) begin
          value[8*i +: 8] = a[XW-8-8*i +: 8];
        end
      end
      op_movi: value = b;
      default: value = '0;  // unused encodings
    endcase
    calc.s = value[XW-1];
    calc.z = (value == '0);
  end

  always_comb begin
    res.dst       = ex.dst;
    res.value     = value;
    res.executed  = cond_ok;
    res.set_flags = ex.set_flags;
    // old flags ride along when this op does not update them
    res.flags     = (ex.set_flags && cond_ok) ? calc : ex.flags;
  end

endmodule

/* src/issue_scoreboard.sv */
`include "exec_defs.svh"

module issue_scoreboard (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  exec_pkg::dispatch_t in,
  output logic [`REG_AW-1:0]  rd_a_idx,
  output logic [`REG_AW-1:0]  rd_b_idx,
  input  logic [`XLEN-1:0]    rd_a,
  input  logic [`XLEN-1:0]    rd_b,
  input  exec_pkg::flags_t    flags,
  output logic                iss_valid,
  input  logic                iss_ready,
  output exec_pkg::exec_t     iss,
  input  logic                wb_valid,
  input  exec_pkg::result_t   wb
);

  import exec_pkg::*;

  logic [`NREGS-1:0] busy;     // one pending writer per register
  logic              fl_busy;
  logic              need_b;
  logic              need_fl;
  logic              hazard;
  logic              issue_fire;

  assign rd_a_idx = in.src_a;
  assign rd_b_idx = in.src_b;

  assign need_b = ~in.use_imm;

  // predicated ops read the flags, flag setters must not overtake one another
  assign need_fl = (in.cond != cond_al) || in.set_flags;

  // busy dst also stalls, otherwise an older writeback would
  // clear the bit while a younger write to it is still in flight
  assign hazard = busy[in.src_a]
                | (need_b & busy[in.src_b])
                | (need_fl & fl_busy)
                | busy[in.dst];

  assign iss_valid  = in_valid & ~hazard;
  assign in_ready   = ~rst & iss_ready & ~hazard;
  assign issue_fire = in_valid & in_ready;

  // operand fetch
  always_comb begin
    iss.op        = in.op;
    iss.cond      = in.cond;
    iss.dst       = in.dst;
    iss.set_flags = in.set_flags;
    iss.a         = rd_a;
    iss.b         = in.use_imm ? in.imm : rd_b;
    iss.flags     = flags;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= '0;
      fl_busy <= 1'b0;
    end else begin
      // clear on the result transfer, executed or skipped
      if (wb_valid) begin
        busy[wb.dst] <= 1'b0;
        if (wb.set_flags) begin
          fl_busy <= 1'b0;
        end
      end
      // later assignment, so a same-cycle issue wins over the clear
      if (issue_fire) begin
        busy[in.dst] <= 1'b1;
        if (in.set_flags) begin
          fl_busy <= 1'b1;
        end
      end
    end
  end

endmodule

/* src/reg_file.sv */
`include "exec_defs.svh"

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  logic [`REG_AW-1:0]  rd_a_idx,
  input  logic [`REG_AW-1:0]  rd_b_idx,
  output logic [`XLEN-1:0]    rd_a,
  output logic [`XLEN-1:0]    rd_b,
  output exec_pkg::flags_t    flags,
  input  logic                wr_en,
  input  logic [`REG_AW-1:0]  wr_idx,
  input  logic [`XLEN-1:0]    wr_data,
  input  logic                fl_wr_en,
  input  exec_pkg::flags_t    fl_wr
);

  logic [`XLEN-1:0] regs [`NREGS];

  // combinational read, no bypass needed since the scoreboard stalls readers
  assign rd_a = regs[rd_a_idx];
  assign rd_b = regs[rd_b_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // separate port, a skipped op may still pass here without touching flags
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (fl_wr_en) begin
      flags <= fl_wr;
    end
  end

endmodule

/* src/pipe_stage.sv */
module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,
  output logic     dn_valid,
  input  logic     dn_ready,
  output payload_t dn_data
);

  // empty or draining this cycle
  assign up_ready = ~dn_valid | dn_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      dn_valid <= 1'b0;
    end else if (up_ready) begin
      dn_valid <= up_valid;
    end
  end

  // payload only moves on an upstream transfer
  always_ff @(posedge clk) begin
    if (up_valid && up_ready) begin
      dn_data <= up_data;
    end
  end

endmodule

/* src/exec_pkg.sv */
`include "exec_defs.svh"

package exec_pkg;

  typedef logic [`XLEN-1:0]   word_t;
  typedef logic [`REG_AW-1:0] reg_idx_t;

  // unary ops (sxtb, sxth, bswap) take operand a, movi takes operand b
  typedef enum logic [`OP_W-1:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_shl,
    op_shr,
    op_sar,
    op_sxtb,
    op_sxth,
    op_bswap,
    op_movi
  } alu_op_e;

  typedef enum logic [`COND_W-1:0] {
    cond_eq, cond_ne,
    cond_cs, cond_cc,
    cond_mi, cond_pl,
    cond_vs, cond_vc,
    cond_hi, cond_ls,
    cond_ge, cond_lt,
    cond_gt, cond_le,
    cond_al, cond_nv
  } cond_e;

  typedef struct packed {
    logic c;
    logic v;
    logic s;
    logic z;
  } flags_t;

  typedef struct packed {
    alu_op_e  op;
    cond_e    cond;
    reg_idx_t dst;
    reg_idx_t src_a;
    reg_idx_t src_b;
    logic     use_imm;
    word_t    imm;
    logic     set_flags;
  } dispatch_t;

  typedef struct packed {
    alu_op_e  op;
    cond_e    cond;
    reg_idx_t dst;
    logic     set_flags;
    word_t    a;
    word_t    b;      // immediate already selected
    flags_t   flags;  // flag register as read at issue
  } exec_t;

  typedef struct packed {
    reg_idx_t dst;
    word_t    value;
    flags_t   flags;  // flag register after this op
    logic     executed;
    logic     set_flags;
  } result_t;

endpackage

/* include/exec_defs.svh */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// datapath width
`define XLEN 32

// general registers, flags live in their own register
`define NREGS 16
`define REG_AW 4

// instruction fields
`define OP_W 4
`define COND_W 4

`endif
